// File: pitch_game_pkg.sv
package pitch_game_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    localparam int mic_width    = 24;
    localparam int period_width = 20;
    localparam int note_width   = 12;
    localparam int index_width  = 6;
    localparam int song_length  = 62;

    // Window factors in percent
    localparam int tolerance_high = 103;
    localparam int tolerance_low  = 97;

    // ------------------------------------------------------------------------
    // Notes, one-hot with C in the top bit
    // ------------------------------------------------------------------------

    typedef logic [note_width - 1:0] note_t;

    localparam note_t no_note  = 12'b0000_0000_0000;
    localparam note_t note_c   = 12'b1000_0000_0000;
    localparam note_t note_cs  = 12'b0100_0000_0000;
    localparam note_t note_d   = 12'b0010_0000_0000;
    localparam note_t note_ds  = 12'b0001_0000_0000;
    localparam note_t note_e   = 12'b0000_1000_0000;
    localparam note_t note_f   = 12'b0000_0100_0000;
    localparam note_t note_fs  = 12'b0000_0010_0000;
    localparam note_t note_g   = 12'b0000_0001_0000;
    localparam note_t note_gs  = 12'b0000_0000_1000;
    localparam note_t note_a   = 12'b0000_0000_0100;
    localparam note_t note_as  = 12'b0000_0000_0010;
    localparam note_t note_b   = 12'b0000_0000_0001;

    // Frequency x 100, entry 0 is C
    localparam logic [18:0] note_freq_100 [note_width] = '{
        19'd26163, 19'd27718, 19'd29366, 19'd31113, 19'd32963, 19'd34923,
        19'd36999, 19'd39200, 19'd41530, 19'd44000, 19'd46616, 19'd49388
    };

    // ------------------------------------------------------------------------
    // Seven-segment patterns, abcdefgh
    // ------------------------------------------------------------------------

    typedef logic [7:0] seg_t;

    localparam seg_t seg_no_note = 8'b0000_0010;

    function automatic seg_t note_to_seg(input note_t note);
        case (note)
            note_c:  return 8'b1001_1100;
            note_cs: return 8'b1001_1101;
            note_d:  return 8'b0111_1010;
            note_ds: return 8'b0111_1011;
            note_e:  return 8'b1001_1110;
            note_f:  return 8'b1000_1110;
            note_fs: return 8'b1000_1111;
            note_g:  return 8'b1011_1100;
            note_gs: return 8'b1011_1101;
            note_a:  return 8'b1110_1110;
            note_as: return 8'b1110_1111;
            note_b:  return 8'b0011_1110;
            default: return seg_no_note;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Game
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        idle    = 2'd0,
        playing = 2'd1,
        win     = 2'd2,
        fail    = 2'd3
    } game_state_t;

    typedef struct packed {
        game_state_t              state;
        logic [index_width - 1:0] index;
    } game_status_t;

    // The song, in singing order
    localparam note_t song_notes [song_length] = '{
        note_e, note_g, note_d, note_c, note_d, note_e, note_g, note_d,
        note_e, note_g, note_d, note_c, note_g, note_f, note_e, note_d,
        note_e, note_g, note_d, note_c, note_d, note_e, note_g, note_d,
        note_e, note_g, note_d, note_c, note_g,
        note_g, note_f, note_e, note_f, note_e, note_c,
        note_f, note_e, note_d, note_e, note_d, note_a,
        note_g, note_f, note_e, note_f, note_e, note_c, note_f, note_c,
        note_e, note_g, note_d, note_c, note_d, note_e, note_g, note_d,
        note_e, note_g, note_d, note_c, note_g
    };

endpackage

// File: zero_cross_period.sv
`timescale 1ns/10ps

module zero_cross_period (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [pitch_game_pkg::mic_width - 1:0]    mic,
    output logic [pitch_game_pkg::period_width - 1:0] period
);

    localparam int sign_bit = pitch_game_pkg::mic_width - 1;

    logic                                      prev_sign;
    logic [pitch_game_pkg::period_width - 1:0] count;
    logic                                      rising;

    // Negative to non-negative between two samples
    assign rising = prev_sign && !mic[sign_bit];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_sign <= 1'b0;
            count     <= '0;
            period    <= '0;
        end else begin
            prev_sign <= mic[sign_bit];
            if (rising) begin
                period <= count;
                count  <= '0;
            end else if (!(&count)) begin
                // Silence or very low tones park the count at full scale
                count <= count + 1'b1;
            end
        end
    end

    // An unknown sign bit would fake crossings
    sign_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(mic[sign_bit])
    ) else $error("zero_cross_period: sign bit of mic is unknown");

endmodule

// File: note_classifier.sv
`timescale 1ns/10ps

module note_classifier #(
    parameter int clk_mhz = 50
) (
    input  logic [pitch_game_pkg::period_width - 1:0] period,
    output pitch_game_pkg::note_t                     note
);

    localparam longint clk_hz = longint'(clk_mhz) * 1000000;

    // ------------------------------------------------------------------------
    // Period windows, three octaves per note
    // ------------------------------------------------------------------------

    for (genvar n = 0; n < pitch_game_pkg::note_width; n++) begin : g_note

        logic [2:0] in_window;

        for (genvar m = 0; m < 3; m++) begin : g_octave
            // Multiplier 1, 2 or 4 on the base frequency
            localparam longint divisor =
                longint'(pitch_game_pkg::note_freq_100[n]) << m;

            // Cycles per period x percent, scaled down by the x100 frequency
            localparam longint low_bound =
                clk_hz * pitch_game_pkg::tolerance_low / divisor;
            localparam longint high_bound =
                clk_hz * pitch_game_pkg::tolerance_high / divisor;

            assign in_window[m] = (period > low_bound) && (period < high_bound);
        end

        // Entry 0 is C, which sits in the top bit
        assign note[pitch_game_pkg::note_width - 1 - n] = |in_window;
    end

    // Windows of neighbouring notes must not claim the same period
    note_one_hot: assert final ($onehot0(note))
        else $error("note_classifier: period %0d hits several notes (%b)", period, note);

endmodule

// File: note_stabilizer.sv
`timescale 1ns/10ps

module note_stabilizer #(
    parameter int stability_width = 20
) (
    input  logic                  clk,
    input  logic                  rst,
    input  pitch_game_pkg::note_t note,
    output pitch_game_pkg::note_t held_note,
    output logic                  new_note
);

    pitch_game_pkg::note_t        prev_note;
    logic [stability_width - 1:0] count;
    logic                         stable;

    // A full run of identical samples
    assign stable = &count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_note <= pitch_game_pkg::no_note;
            count     <= '0;
        end else begin
            prev_note <= note;
            if (note == prev_note) begin
                count <= count + 1'b1;
            end else begin
                count <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Held note and change strobe
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_note <= pitch_game_pkg::no_note;
            new_note  <= 1'b0;
        end else begin
            new_note <= 1'b0;
            if (stable) begin
                held_note <= prev_note;
                // Only a change to a sounding note counts as a new one
                new_note  <= (prev_note != held_note) &&
                             (prev_note != pitch_game_pkg::no_note);
            end
        end
    end

    // Overlapping windows could hand over several notes at once
    strobe_has_note: assert property (
        @(posedge clk) disable iff (rst)
        new_note |-> $onehot(held_note)
    ) else $error("note_stabilizer: strobe without a single sounding note");

endmodule

// File: song_tracker.sv
`timescale 1ns/10ps

module song_tracker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         key,
    input  pitch_game_pkg::note_t        held_note,
    input  logic                         new_note,
    output pitch_game_pkg::game_status_t status
);

    localparam logic [pitch_game_pkg::index_width - 1:0] last_index =
        pitch_game_pkg::index_width'(pitch_game_pkg::song_length - 1);
    localparam logic [pitch_game_pkg::index_width - 1:0] index_step =
        pitch_game_pkg::index_width'(1);

    logic prev_key;
    logic press;

    // ------------------------------------------------------------------------
    // Key press detection
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_key <= 1'b0;
            press    <= 1'b0;
        end else begin
            prev_key <= key;
            press    <= key && !prev_key;
        end
    end

    // ------------------------------------------------------------------------
    // Game FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status.state <= pitch_game_pkg::idle;
            status.index <= '0;
        end else begin
            case (status.state)
                pitch_game_pkg::idle: begin
                    if (press) begin
                        status.index <= '0;
                        status.state <= pitch_game_pkg::playing;
                    end
                end

                pitch_game_pkg::playing: begin
                    // Abandon keeps the position for display
                    if (press) begin
                        status.state <= pitch_game_pkg::idle;
                    end else if (new_note) begin
                        if (held_note == pitch_game_pkg::song_notes[status.index]) begin
                            if (status.index == last_index) begin
                                status.state <= pitch_game_pkg::win;
                            end else begin
                                status.index <= status.index + index_step;
                            end
                        end else begin
                            status.state <= pitch_game_pkg::fail;
                        end
                    end
                end

                pitch_game_pkg::fail: begin
                    status.index <= '0;
                    if (press) begin
                        status.state <= pitch_game_pkg::idle;
                    end
                end

                pitch_game_pkg::win: begin
                    if (press) begin
                        status.state <= pitch_game_pkg::idle;
                    end
                end

                default: begin
                    status.state <= pitch_game_pkg::idle;
                end
            endcase
        end
    end

    // The song table lookup depends on this
    index_in_song: assert property (
        @(posedge clk) disable iff (rst)
        status.index < pitch_game_pkg::song_length
    ) else $error("song_tracker: index %0d past end of song", status.index);

endmodule

// File: status_display.sv
`timescale 1ns/10ps

module status_display (
    input  logic                         clk,
    input  logic                         rst,
    input  pitch_game_pkg::note_t        held_note,
    input  pitch_game_pkg::game_status_t status,
    output logic [7:0]                   led,
    output pitch_game_pkg::seg_t         abcdefgh
);

    pitch_game_pkg::seg_t seg_next;

    // ------------------------------------------------------------------------
    // Seven-segment digit
    // ------------------------------------------------------------------------

    //   --a--
    //  |     |
    //  f     b
    //   --g--
    //  e     c
    //   --d--  h

    // Non one-hot codes fall through to the dash
    assign seg_next = pitch_game_pkg::note_to_seg(held_note);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            abcdefgh <= '0;
        end else begin
            abcdefgh <= seg_next;
        end
    end

    // ------------------------------------------------------------------------
    // LEDs
    // ------------------------------------------------------------------------

    // State on the top two LEDs, song position below
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led <= '0;
        end else begin
            led <= {status.state, status.index};
        end
    end

endmodule

// File: pitch_game_top.sv
`timescale 1ns/10ps

module pitch_game_top #(
    parameter int clk_mhz         = 50,
    parameter int stability_width = 20
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   key,
    input  logic [pitch_game_pkg::mic_width - 1:0] mic,
    output logic [7:0]                             led,
    output pitch_game_pkg::seg_t                   abcdefgh
);

    logic [pitch_game_pkg::period_width - 1:0] period;
    pitch_game_pkg::note_t                     note;
    pitch_game_pkg::note_t                     held_note;
    logic                                      new_note;
    pitch_game_pkg::game_status_t              status;

    zero_cross_period u_zero_cross_period (
        .clk    (clk),
        .rst    (rst),
        .mic    (mic),
        .period (period)
    );

    note_classifier #(
        .clk_mhz (clk_mhz)
    ) u_note_classifier (
        .period (period),
        .note   (note)
    );

    note_stabilizer #(
        .stability_width (stability_width)
    ) u_note_stabilizer (
        .clk       (clk),
        .rst       (rst),
        .note      (note),
        .held_note (held_note),
        .new_note  (new_note)
    );

    song_tracker u_song_tracker (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .held_note (held_note),
        .new_note  (new_note),
        .status    (status)
    );

    status_display u_status_display (
        .clk       (clk),
        .rst       (rst),
        .held_note (held_note),
        .status    (status),
        .led       (led),
        .abcdefgh  (abcdefgh)
    );

endmodule

// File: tb_pitch_game.sv
`timescale 1ns/10ps

module tb_pitch_game;

    localparam int rest_period   = 5000;
    localparam int timeout_limit = 20 * pitch_game_pkg::song_length * rest_period;

    logic                                   clk = 1'b0;
    logic                                   rst;
    logic                                   key;
    logic [pitch_game_pkg::mic_width - 1:0] mic;
    logic [7:0]                             led;
    pitch_game_pkg::seg_t                   abcdefgh;

    // Model state
    pitch_game_pkg::game_state_t exp_state;
    logic [5:0]                  exp_index;
    logic [7:0]                  exp_seg;

    integer seed = 94;
    int     cycle_count = 0;
    int     check_count = 0;
    int     error_count = 0;
    int     test_errors = 0;
    int     test_number = 0;

    pitch_game_top #(
        .clk_mhz         (1),
        .stability_width (4)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .mic      (mic),
        .led      (led),
        .abcdefgh (abcdefgh)
    );

    always #20 clk = ~clk;

    // Hard stop well beyond the longest possible run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: simulation ran past %0d clock cycles", timeout_limit);
            $display("Test failures found");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function automatic int pick(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // Tone period in cycles at 1 MHz, note 0 is C
    function automatic int tone_period(input int n, input int mult);
        return 100000000 / (int'(pitch_game_pkg::note_freq_100[n]) * mult);
    endfunction

    function automatic logic [7:0] seg_for(input int n);
        case (n)
            0:       return 8'b1001_1100;
            1:       return 8'b1001_1101;
            2:       return 8'b0111_1010;
            3:       return 8'b0111_1011;
            4:       return 8'b1001_1110;
            5:       return 8'b1000_1110;
            6:       return 8'b1000_1111;
            7:       return 8'b1011_1100;
            8:       return 8'b1011_1101;
            9:       return 8'b1110_1110;
            10:      return 8'b1110_1111;
            11:      return 8'b0011_1110;
            default: return 8'b0000_0010;
        endcase
    endfunction

    function automatic int index_of(input pitch_game_pkg::note_t note);
        for (int b = 0; b < 12; b++) begin
            if (note[11 - b]) begin
                return b;
            end
        end
        return -1;
    endfunction

    // High half first, so each rising edge closes one whole tone period
    task automatic play_tone(input int period_cycles, input int periods);
        int          half;
        logic [22:0] level;
        half  = period_cycles / 2;
        level = $random(seed);
        repeat (periods) begin
            repeat (half) begin
                @(posedge clk);
                mic <= {1'b0, level};
            end
            repeat (period_cycles - half) begin
                @(posedge clk);
                mic <= {1'b1, level};
            end
        end
    endtask

    task automatic check_outputs(input string what);
        logic [7:0] exp_led;
        @(negedge clk);
        exp_led = {exp_state, exp_index};
        check_count++;
        assert (led == exp_led) else begin
            $display("** Error at %0t ns: %s, led expected %b, got %b",
                     $time, what, exp_led, led);
            error_count++;
        end
        assert (abcdefgh == exp_seg) else begin
            $display("** Error at %0t ns: %s, abcdefgh expected %b, got %b",
                     $time, what, exp_seg, abcdefgh);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Game model
    // ------------------------------------------------------------------------

    task automatic model_note(input int n);
        if (exp_state == pitch_game_pkg::playing) begin
            if (n == index_of(pitch_game_pkg::song_notes[exp_index])) begin
                if (exp_index == pitch_game_pkg::song_length - 1) begin
                    exp_state = pitch_game_pkg::win;
                end else begin
                    exp_index = exp_index + 1;
                end
            end else begin
                exp_state = pitch_game_pkg::fail;
                exp_index = '0;
            end
        end
    endtask

    task automatic press_key();
        @(posedge clk);
        key <= 1'b1;
        repeat (3) @(posedge clk);
        key <= 1'b0;
        repeat (4) @(posedge clk);
        if (exp_state == pitch_game_pkg::idle) begin
            exp_state = pitch_game_pkg::playing;
            exp_index = '0;
        end else begin
            exp_state = pitch_game_pkg::idle;
        end
        check_outputs("key press");
    endtask

    // One sung note followed by an off-pitch gap
    task automatic sing_note(input int n, input int mult);
        play_tone(tone_period(n, mult), 4);
        model_note(n);
        exp_seg = seg_for(n);
        check_outputs($sformatf("note %0d x%0d", n, mult));
        play_tone(rest_period, 4);
        exp_seg = seg_for(-1);
        check_outputs("rest");
    endtask

    task automatic end_test(input string name);
        test_number++;
        $display("Test %0d (%s) finished with %0d errors",
                 test_number, name, error_count - test_errors);
        test_errors = error_count;
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        int count;
        int wrong;

        rst       = 1'b1;
        key       = 1'b0;
        mic       = '0;
        exp_state = pitch_game_pkg::idle;
        exp_index = '0;
        exp_seg   = seg_for(-1);

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        check_outputs("after reset");
        end_test("reset");

        for (int i = 0; i < 40; i++) begin
            sing_note(pick(12), 1 << pick(3));
        end
        end_test("random notes");

        press_key();
        count = 1 + pick(12);
        for (int i = 0; i < count; i++) begin
            sing_note(index_of(pitch_game_pkg::song_notes[exp_index]), 1 << pick(3));
        end
        end_test("song start");

        wrong = (index_of(pitch_game_pkg::song_notes[exp_index]) + 1 + pick(11)) % 12;
        sing_note(wrong, 1 << pick(3));
        press_key();
        end_test("wrong note");

        press_key();
        for (int i = 0; i < pitch_game_pkg::song_length; i++) begin
            sing_note(index_of(pitch_game_pkg::song_notes[i]), 1 << pick(3));
        end
        press_key();
        end_test("whole song");

        press_key();
        count = 1 + pick(20);
        for (int i = 0; i < count; i++) begin
            sing_note(index_of(pitch_game_pkg::song_notes[exp_index]), 1 << pick(3));
        end
        press_key();
        end_test("abandon");

        $display("Tests: %0d, checks: %0d, errors: %0d", test_number, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: pitch_game_top.f
pitch_game_pkg.sv
zero_cross_period.sv
note_classifier.sv
note_stabilizer.sv
song_tracker.sv
status_display.sv
pitch_game_top.sv
tb_pitch_game.sv
